// File: all.f
src/lcdPkg.sv
src/lcdFillSequencer.sv
src/lcdXferFifo.sv
src/lcdSpiWriter.sv
src/lcdSubsystem.sv
tests/spiLcdMonitor.sv
tests/lcdSubsystemTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module lcdSubsystemTb -o simLcd
out=$(./obj_dir/simLcd)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

// File: tests/lcdSubsystemTb.sv
// uses a 4-entry FIFO so fills hit back-pressure; stream is checked per request once busy has fallen
`default_nettype none

module lcdSubsystemTb import lcdPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum {ROW_FILL, ROW_RAW, ROW_FILL_BUSY} rowKind;

	typedef struct {
		rowKind kind;
		fillReq fillArgs;
		rawReq rawArgs;
		int pixels;	// expected pixel words of a fill
	} testRow;

	localparam int ROWS = 9;

	logic clk;
	logic rstN;
	logic fillStart;
	fillReq fill;
	logic rawStart;
	rawReq raw;
	logic busy;
	logic CSX;
	logic DCX;
	logic SCK;
	logic SDO;
	logic evValid;
	logic [9:0] evWord;
	int protoErrors;

	testRow rows [ROWS];
	logic [9:0] expQ[$];	// {release, dcx, byte}
	logic [9:0] rxQ[$];
	logic expCsx = 1'b1;	// CSX level after the last expected event
	int errors = 0;
	int cycles = 0;
	int cycleLimit = 0;

	lcdSubsystem #(
		.FIFO_DEPTH(4)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.fillStart(fillStart),
		.fill(fill),
		.rawStart(rawStart),
		.raw(raw),
		.busy(busy),
		.CSX(CSX),
		.DCX(DCX),
		.SCK(SCK),
		.SDO(SDO)
	);

	spiLcdMonitor i_mon (
		.clk(clk),
		.rstN(rstN),
		.CSX(CSX),
		.DCX(DCX),
		.SCK(SCK),
		.SDO(SDO),
		.evValid(evValid),
		.evWord(evWord),
		.protoErrors(protoErrors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (evValid) rxQ.push_back(evWord);
	end

	// watchdog with its limit set from the table before the first request
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic testRow rawRow(logic [7:0] data, logic dcx, logic rel);
		testRow r;
		r.kind = ROW_RAW;
		r.fillArgs = '0;
		r.rawArgs = '{data: data, dcx: dcx, csRelease: rel};
		r.pixels = 0;
		return r;
	endfunction

	function automatic testRow fillRow(rowKind kind, logic [7:0] x0, logic [7:0] x1,
			logic [8:0] y0, logic [8:0] y1, logic [15:0] color, int pixels);
		testRow r;
		r.kind = kind;
		r.fillArgs = '{x0: x0, x1: x1, y0: y0, y1: y1, color: color};
		r.rawArgs = '0;
		r.pixels = pixels;
		return r;
	endfunction

	function automatic int rowBytes(testRow r);
		if (r.kind == ROW_RAW) return 1;
		return 12 + 2 * r.pixels;	// 11 header bytes, pixels, release
	endfunction

	function automatic string eventText(logic [9:0] w);
		if (w[9]) return "release";
		return $sformatf("%s %h", w[8] ? "data" : "cmd", w[7:0]);
	endfunction

	// expected stream straight from the entry sequence rules
	task automatic addExpected(testRow r);
		if (r.kind == ROW_RAW) begin
			if (r.rawArgs.csRelease) expQ.push_back(10'h200);
			else expQ.push_back({1'b0, r.rawArgs.dcx, r.rawArgs.data});
			expCsx = r.rawArgs.csRelease;
		end else begin
			expQ.push_back({2'b00, CMD_CASET});
			expQ.push_back({2'b01, 8'h00});	// x high bytes are zero
			expQ.push_back({2'b01, r.fillArgs.x0});
			expQ.push_back({2'b01, 8'h00});
			expQ.push_back({2'b01, r.fillArgs.x1});
			expQ.push_back({2'b00, CMD_PASET});
			expQ.push_back({2'b01, 7'b0, r.fillArgs.y0[8]});
			expQ.push_back({2'b01, r.fillArgs.y0[7:0]});
			expQ.push_back({2'b01, 7'b0, r.fillArgs.y1[8]});
			expQ.push_back({2'b01, r.fillArgs.y1[7:0]});
			expQ.push_back({2'b00, CMD_RAMWR});
			for (int i = 0; i < r.pixels; i++) begin
				expQ.push_back({2'b01, r.fillArgs.color[15:8]});	// high byte first
				expQ.push_back({2'b01, r.fillArgs.color[7:0]});
			end
			expQ.push_back(10'h200);
			expCsx = 1'b1;
		end
	endtask

	task automatic checkLevel(string name, logic expected, logic received);
		if (expected !== received) begin
			$display("FAIL t=%0t signal=%s expected=%b received=%b", $time, name, expected,
				received);
			errors++;
		end
	endtask

	task automatic compareStream();
		logic [9:0] e;
		logic [9:0] g;
		while (expQ.size() > 0 && rxQ.size() > 0) begin
			e = expQ.pop_front();
			g = rxQ.pop_front();
			if (e[9] != g[9]) begin
				$display("FAIL t=%0t signal=CSX expected=%s received=%s", $time,
					eventText(e), eventText(g));
				errors++;
			end else if (!e[9] && e[7:0] != g[7:0]) begin
				$display("FAIL t=%0t signal=SDO expected=%h received=%h", $time, e[7:0], g[7:0]);
				errors++;
			end else if (!e[9] && e[8] != g[8]) begin
				$display("FAIL t=%0t signal=DCX expected=%b received=%b", $time, e[8], g[8]);
				errors++;
			end
		end
		if (expQ.size() > 0) begin
			$display("at %0t %0d expected events never arrived, first missing is %s", $time,
				expQ.size(), eventText(expQ[0]));
			errors++;
			expQ.delete();
		end
		if (rxQ.size() > 0) begin
			$display("at %0t %0d extra events arrived, first extra is %s", $time,
				rxQ.size(), eventText(rxQ[0]));
			errors++;
			rxQ.delete();
		end
	endtask

	task automatic applyRow(testRow r);
		@(posedge clk);
		if (r.kind == ROW_RAW) begin
			raw <= r.rawArgs;
			rawStart <= 1'b1;
		end else begin
			fill <= r.fillArgs;
			fillStart <= 1'b1;
		end
		@(posedge clk);
		fillStart <= 1'b0;
		rawStart <= 1'b0;
		if (r.kind == ROW_FILL_BUSY) begin
			// header fully sent so the sequencer is idle and only busy can block
			while (rxQ.size() < 11) @(posedge clk);
			if (!busy) begin
				$display("at %0t busy was low while pixels were still pending", $time);
				errors++;
			end
			fill <= '{x0: 8'd0, x1: 8'd3, y0: 9'd0, y1: 9'd3, color: 16'hFFFF};	// must be dropped
			fillStart <= 1'b1;
			@(posedge clk);
			fillStart <= 1'b0;
			raw <= '{data: 8'hEE, dcx: 1'b1, csRelease: 1'b0};	// dropped as well
			rawStart <= 1'b1;
			@(posedge clk);
			rawStart <= 1'b0;
		end
		@(posedge clk);
		while (busy) @(posedge clk);
		repeat (3) @(posedge clk);	// last event still crossing the monitor
	endtask

	initial begin
		rstN = 1'b0;
		fillStart = 1'b0;
		rawStart = 1'b0;
		fill = '0;
		raw = '0;

		rows[0] = rawRow(8'h29, 1'b0, 1'b0);	// command byte
		rows[1] = rawRow(8'hA5, 1'b1, 1'b0);	// data byte that keeps CSX low
		rows[2] = rawRow(8'h00, 1'b0, 1'b1);	// release
		rows[3] = fillRow(ROW_FILL, 8'd10, 8'd10, 9'd300, 9'd300, 16'hF81F, 1);
		rows[4] = fillRow(ROW_FILL, 8'd2, 8'd6, 9'd20, 9'd22, 16'h07E0, 15);	// beyond FIFO depth
		rows[5] = fillRow(ROW_FILL_BUSY, 8'd0, 8'd1, 9'd5, 9'd5, 16'h1234, 2);
		rows[6] = rawRow(8'h2C, 1'b0, 1'b0);
		rows[7] = rawRow(8'h5A, 1'b1, 1'b0);
		rows[8] = rawRow(8'h00, 1'b0, 1'b1);
		for (int i = 0; i < ROWS; i++) cycleLimit += 40 * rowBytes(rows[i]) + 200;

		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		checkLevel("CSX", 1'b1, CSX);
		checkLevel("SCK", 1'b0, SCK);
		checkLevel("busy", 1'b0, busy);
		repeat (8) @(posedge clk);
		if (rxQ.size() != 0) begin
			$display("at %0t %0d events arrived before any request", $time, rxQ.size());
			errors++;
			rxQ.delete();
		end

		for (int i = 0; i < ROWS; i++) begin
			addExpected(rows[i]);
			applyRow(rows[i]);
			compareStream();
			checkLevel("CSX", expCsx, CSX);
			checkLevel("SCK", 1'b0, SCK);
		end

		$display("errors: %0d stream, %0d protocol, %0d total", errors, protoErrors,
			errors + protoErrors);
		if (errors + protoErrors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/spiLcdMonitor.sv
// samples on the falling clk edge, so SCK must stay at clk/2 or slower; CSX rises are passed on as release events
`default_nettype none

module spiLcdMonitor (
	input wire logic clk,
	input wire logic rstN,
	input wire logic CSX,
	input wire logic DCX,
	input wire logic SCK,
	input wire logic SDO,
	output logic evValid,	// one clk period per event
	output logic [9:0] evWord,	// {release, dcx, byte}
	output int protoErrors	// framing and select violations
);

	timeunit 1ns;
	timeprecision 1ps;

	logic prevSck;
	logic prevCsx;
	logic byteDcx;	// DCX seen on the first bit of a byte
	logic [7:0] shiftIn;
	int bitCnt;

	// mid-cycle sampling keeps clear of the edge where DUT outputs move
	always @(negedge clk) begin
		evValid <= 1'b0;
		if (!rstN) begin
			prevSck <= 1'b0;
			prevCsx <= 1'b1;	// panel deselected in reset
			byteDcx <= 1'b0;
			shiftIn <= '0;
			evWord <= '0;
			bitCnt <= 0;
			protoErrors = 0;
		end else begin
			prevSck <= SCK;
			prevCsx <= CSX;
			if (SCK && !prevSck) begin	// SCK rising edge
				if (CSX) begin
					$display("protocol error at %0t: SCK pulsed while CSX was high", $time);
					protoErrors = protoErrors + 1;
				end
				if (bitCnt != 0 && DCX != byteDcx) begin
					$display("protocol error at %0t: DCX changed inside a byte", $time);
					protoErrors = protoErrors + 1;
				end
				if (bitCnt == 0) byteDcx <= DCX;
				if (bitCnt == 7) begin
					evValid <= 1'b1;
					evWord <= {1'b0, DCX, shiftIn[6:0], SDO};	// msb arrived first
					bitCnt <= 0;
				end else begin
					shiftIn <= {shiftIn[6:0], SDO};
					bitCnt <= bitCnt + 1;
				end
			end
			if (CSX && !prevCsx) begin	// release
				if (bitCnt != 0) begin
					$display("protocol error at %0t: CSX rose after %0d bits of a byte",
						$time, bitCnt);
					protoErrors = protoErrors + 1;
				end
				evValid <= 1'b1;
				evWord <= 10'h200;
				bitCnt <= 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/lcdSubsystem.sv
// strobes arriving while busy are dropped; FIFO_DEPTH must be a power of two
`default_nettype none

module lcdSubsystem import lcdPkg::*; #(
	parameter int FIFO_DEPTH = 8	// transfer entries buffered
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic fillStart,	// one-cycle strobe
	input wire fillReq fill,
	input wire logic rawStart,	// one-cycle strobe
	input wire rawReq raw,
	output logic busy,	// level, low once the panel has seen everything
	output logic CSX,
	output logic DCX,
	output logic SCK,
	output logic SDO
);

	logic push;
	logic pop;
	logic full;
	logic empty;
	logic seqActive;
	logic wrIdle;
	xferEntry pushData;
	xferEntry popData;

	// busy until producer, buffer and consumer have all drained
	assign busy = seqActive || !empty || !wrIdle;

	lcdFillSequencer i_seq (
		.clk(clk),
		.rstN(rstN),
		.fillStart(fillStart && !busy),	// requests only while fully idle
		.fill(fill),
		.rawStart(rawStart && !busy),
		.raw(raw),
		.full(full),
		.push(push),
		.pushData(pushData),
		.active(seqActive)
	);

	lcdXferFifo #(
		.DEPTH(FIFO_DEPTH)
	) i_fifo (
		.clk(clk),
		.rstN(rstN),
		.push(push),
		.pushData(pushData),
		.pop(pop),
		.popData(popData),
		.full(full),
		.empty(empty)
	);

	lcdSpiWriter i_spi (
		.clk(clk),
		.rstN(rstN),
		.empty(empty),
		.popData(popData),
		.pop(pop),
		.idle(wrIdle),
		.CSX(CSX),
		.DCX(DCX),
		.SCK(SCK),
		.SDO(SDO)
	);

endmodule

`default_nettype wire

// File: src/lcdSpiWriter.sv
// SCK runs at clk/2 MSB first with write only and no MISO; a release keeps DCX and raises CSX
`default_nettype none

module lcdSpiWriter import lcdPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic empty,	// FIFO has no entry
	input wire xferEntry popData,	// head entry, taken on pop
	output logic pop,
	output logic idle,	// nothing in flight
	output logic CSX,	// chip select, active low
	output logic DCX,	// 0 command, 1 data
	output logic SCK,
	output logic SDO
);

	logic shiftActive;	// shifting a byte or pixel
	logic relCycle;	// one cycle for a release
	logic wordMode;	// 16-bit pixel in flight
	logic [4:0] cnt;	// cycle within the entry
	logic [4:0] cntEnd;
	logic [15:0] shiftQ;	// msb drives SDO
	logic csxQ;
	logic dcxQ;
	logic isPixel;
	logic isRelease;
	xferPayload headPayload;

	assign headPayload = popData.payload;
	assign isPixel = (popData.kind == XFER_PIXEL);
	assign isRelease = (popData.kind == XFER_RELEASE);

	assign idle = !shiftActive && !relCycle;
	assign pop = idle && !empty;	// pop cycle doubles as the gap between entries

	assign cntEnd = wordMode ? 5'd31 : 5'd15;	// 16 or 8 SCK pulses

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			shiftActive <= 1'b0;
			relCycle <= 1'b0;
			wordMode <= 1'b0;
			cnt <= '0;
			csxQ <= 1'b1;	// deselected out of reset
			dcxQ <= 1'b0;
		end else begin
			relCycle <= 1'b0;
			if (pop) begin
				cnt <= '0;
				if (isRelease) begin
					relCycle <= 1'b1;
					csxQ <= 1'b1;	// DCX left as is and no bits shifted
				end else begin
					shiftActive <= 1'b1;
					wordMode <= isPixel;
					csxQ <= 1'b0;	// stays low until a release
					dcxQ <= isPixel ? 1'b1 : headPayload.cmd.dcx;
				end
			end else if (shiftActive) begin
				if (cnt == cntEnd) shiftActive <= 1'b0;
				else cnt <= cnt + 5'd1;
			end
		end
	end

	// shift after each SCK high phase so SDO moves while SCK is low
	always_ff @(posedge clk) begin
		if (pop) begin
			if (isPixel) shiftQ <= headPayload.pixel;
			else shiftQ <= {headPayload.cmd.data, 8'h00};	// byte left aligned
		end else if (shiftActive && cnt[0]) begin
			shiftQ <= {shiftQ[14:0], 1'b0};
		end
	end

	assign SCK = shiftActive && cnt[0];	// high on odd cycles
	assign SDO = shiftActive && shiftQ[15];
	assign CSX = csxQ;
	assign DCX = dcxQ;

	// clock only inside a shift window, never during a release
	assert property (@(posedge clk) disable iff (!rstN) SCK |-> !relCycle && (cnt <= cntEnd));

	// panel must be selected whenever it is clocked
	assert property (@(posedge clk) disable iff (!rstN) SCK |-> !CSX);

endmodule

`default_nettype wire

// File: src/lcdXferFifo.sv
// DEPTH must be a power of two; popData is the head entry and is valid only while empty is low
`default_nettype none

module lcdXferFifo import lcdPkg::*; #(
	parameter int DEPTH = 8	// power of two
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic push,	// write strobe, ignored when full
	input wire xferEntry pushData,
	input wire logic pop,	// read strobe, ignored when empty
	output xferEntry popData,
	output logic full,
	output logic empty
);

	localparam int AW = $clog2(DEPTH);

	xferEntry mem [DEPTH];	// entry storage
	logic [AW:0] wrPtr;	// extra msb tells full from empty
	logic [AW:0] rdPtr;
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop = pop && !empty;

	// equal pointers mean empty, wrapped by one lap means full
	assign empty = (wrPtr == rdPtr);
	assign full = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);

	assign popData = mem[rdPtr[AW-1:0]];	// show-ahead

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (doPush) wrPtr <= wrPtr + (AW+1)'(1);
			if (doPop) rdPtr <= rdPtr + (AW+1)'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr[AW-1:0]] <= pushData;
	end

	// producer must honour full
	assert property (@(posedge clk) disable iff (!rstN) push |-> !full);

	// consumer must honour empty
	assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty);

endmodule

`default_nettype wire

// File: src/lcdFillSequencer.sv
// requests are taken only while idle and fill wins a tie; rectangles are neither clipped nor reordered
`default_nettype none

module lcdFillSequencer import lcdPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic fillStart,	// one-cycle strobe
	input wire fillReq fill,
	input wire logic rawStart,	// one-cycle strobe
	input wire rawReq raw,
	input wire logic full,	// FIFO back-pressure
	output logic push,
	output xferEntry pushData,
	output logic active	// entries still to push
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_HEADER,	// CASET, PASET, RAMWR and their address bytes
		S_PIXELS,
		S_RELEASE,
		S_RAW
	} seqState;

	localparam logic [3:0] HDR_LAST = 4'd10;	// 11 header entries

	seqState state;
	logic [3:0] hdrIdx;
	logic [PIXEL_COUNT_W-1:0] pixLeft;
	logic [PIXEL_COUNT_W-1:0] xSpan;
	logic [PIXEL_COUNT_W-1:0] ySpan;
	fillReq fillQ;
	rawReq rawQ;
	logic acceptFill;
	logic acceptRaw;
	logic [7:0] hdrByte;
	logic hdrDcx;

	assign acceptFill = fillStart && (state == S_IDLE);
	assign acceptRaw = rawStart && !fillStart && (state == S_IDLE);	// fill wins

	// spans from the live request, product taken once on acceptance
	assign xSpan = PIXEL_COUNT_W'(fill.x1) - PIXEL_COUNT_W'(fill.x0) + PIXEL_COUNT_W'(1);
	assign ySpan = PIXEL_COUNT_W'(fill.y1) - PIXEL_COUNT_W'(fill.y0) + PIXEL_COUNT_W'(1);

	assign active = (state != S_IDLE);
	assign push = active && !full;	// hold while full

	// header byte selection, addresses big-endian
	always_comb begin
		hdrDcx = 1'b1;
		case (hdrIdx)
			4'd0: begin
				hdrByte = CMD_CASET;
				hdrDcx = 1'b0;
			end
			4'd1: hdrByte = 8'h00;	// x0 high, panel is narrower than 256
			4'd2: hdrByte = fillQ.x0;
			4'd3: hdrByte = 8'h00;
			4'd4: hdrByte = fillQ.x1;
			4'd5: begin
				hdrByte = CMD_PASET;
				hdrDcx = 1'b0;
			end
			4'd6: hdrByte = 8'(fillQ.y0 >> 8);
			4'd7: hdrByte = fillQ.y0[7:0];
			4'd8: hdrByte = 8'(fillQ.y1 >> 8);
			4'd9: hdrByte = fillQ.y1[7:0];
			default: begin
				hdrByte = CMD_RAMWR;	// last header entry
				hdrDcx = 1'b0;
			end
		endcase
	end

	always_comb begin
		pushData = '0;
		case (state)
			S_HEADER: begin
				pushData.kind = XFER_BYTE;
				pushData.payload.cmd.dcx = hdrDcx;
				pushData.payload.cmd.data = hdrByte;
			end
			S_PIXELS: begin
				pushData.kind = XFER_PIXEL;
				pushData.payload.pixel = fillQ.color;
			end
			S_RELEASE: pushData.kind = XFER_RELEASE;
			S_RAW: begin
				pushData.kind = rawQ.csRelease ? XFER_RELEASE : XFER_BYTE;
				pushData.payload.cmd.dcx = rawQ.dcx;
				pushData.payload.cmd.data = rawQ.data;
			end
			default: pushData = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= S_IDLE;
			hdrIdx <= '0;
			pixLeft <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (acceptFill) begin
						state <= S_HEADER;
						hdrIdx <= '0;
						pixLeft <= xSpan * ySpan;	// never zero for a legal rectangle
					end else if (acceptRaw) begin
						state <= S_RAW;
					end
				end
				S_HEADER: if (push) begin
					if (hdrIdx == HDR_LAST) state <= S_PIXELS;
					else hdrIdx <= hdrIdx + 4'd1;
				end
				S_PIXELS: if (push) begin
					if (pixLeft == PIXEL_COUNT_W'(1)) state <= S_RELEASE;
					pixLeft <= pixLeft - PIXEL_COUNT_W'(1);
				end
				S_RELEASE, S_RAW: if (push) state <= S_IDLE;	// single entry
				default: state <= S_IDLE;
			endcase
		end
	end

	// request copies, held for the whole sequence
	always_ff @(posedge clk) begin
		if (acceptFill) fillQ <= fill;
		if (acceptRaw) rawQ <= raw;
	end

	// pixel count is only valid for an ordered rectangle
	assert property (@(posedge clk) disable iff (!rstN)
		acceptFill |-> (fill.x0 <= fill.x1) && (fill.y0 <= fill.y1));

endmodule

`default_nettype wire

// File: src/lcdPkg.sv
// shared LCD write path types assume a 240x320 ILI9341-class panel and a write-only SPI link
`default_nettype none

package lcdPkg;

	localparam int X_W = 8;	// column coordinate width
	localparam int Y_W = 9;	// page coordinate width
	localparam int PIXEL_COUNT_W = 17;	// 240*320 = 76800 fits

	// controller opcodes used by a rectangle fill
	localparam logic [7:0] CMD_CASET = 8'h2A;	// column address set
	localparam logic [7:0] CMD_PASET = 8'h2B;	// page address set
	localparam logic [7:0] CMD_RAMWR = 8'h2C;	// memory write, pixels follow

	// what the SPI writer does with one FIFO entry
	typedef enum logic [1:0] {
		XFER_BYTE = 2'd0,	// 8 bits, command or data
		XFER_PIXEL = 2'd1,	// 16 bits, always data
		XFER_RELEASE = 2'd2	// raise CSX, nothing shifted
	} xferKind;

	typedef struct packed {
		logic dcx;	// 0 command, 1 data
		logic [6:0] pad;	// keeps the byte in the low half
		logic [7:0] data;
	} cmdByte;

	// one 16-bit word, read per entry kind
	typedef union packed {
		cmdByte cmd;	// byte entries
		logic [15:0] pixel;	// pixel entries, RGB565
	} xferPayload;

	// FIFO word
	typedef struct packed {
		xferKind kind;
		xferPayload payload;
	} xferEntry;

	// inclusive rectangle
	typedef struct packed {
		logic [X_W-1:0] x0;
		logic [X_W-1:0] x1;
		logic [Y_W-1:0] y0;
		logic [Y_W-1:0] y1;
		logic [15:0] color;
	} fillReq;

	// single byte or chip-select release
	typedef struct packed {
		logic [7:0] data;
		logic dcx;	// 0 command, 1 data
		logic csRelease;	// set means release only, data ignored
	} rawReq;

endpackage

`default_nettype wire
